// ==== verilog/tcb_bus_pkg.sv ====
// TCB bus package with widths, response delay and the response-side request record
package tcb_bus_pkg;

    ////////////////////
    // handshake
    ////////////////////

    // response delay in clock cycles
    localparam int unsigned dly = 1;

    ////////////////////
    // bus widths
    ////////////////////

    // data width
    localparam int unsigned dat_w = 32;
    // bytes per data word
    localparam int unsigned byt_n = dat_w / 8;
    // byte offset inside a word
    localparam int unsigned off_w = $clog2(byt_n);
    // logarithmic size, 0/1/2 for 1/2/4 bytes
    localparam int unsigned siz_w = 2;
    // byte address
    localparam int unsigned adr_w = 12;

    ////////////////////
    // response record
    ////////////////////

    // request fields the response side needs
    // to rotate read data back into place
    typedef struct packed {
        // endianness (0 little, 1 big)
        logic             ndn;
        // logarithmic size
        logic [siz_w-1:0] siz;
        // low address bits
        logic [off_w-1:0] off;
    } rsp_meta_t;

endpackage

// ==== verilog/tcb_mem_pkg.sv ====
// TCB memory package with the depth and address range of the byte-enabled word memory
package tcb_mem_pkg;

    ////////////////////
    // memory geometry
    ////////////////////

    // number of data words
    localparam int unsigned mem_words = 512;

    // word index width
    localparam int unsigned mem_idx_w = $clog2(mem_words);

    ////////////////////
    // address range
    ////////////////////

    // first byte address outside the array
    // accesses here or above flag an error
    localparam int unsigned mem_adr_lim = mem_words * tcb_bus_pkg::byt_n;

endpackage

// ==== verilog/tcb_dly_line.sv ====
// TCB delay line shifting a payload of any type through the bus response delay
module tcb_dly_line #(
    // payload carried through the stages
    parameter type payload_t = logic
)(
    input  logic     clk,
    input  logic     reset,
    // payload entering the line
    input  payload_t din,
    // payload leaving after dly cycles
    output payload_t dout
);

    ////////////////////
    // register stages
    ////////////////////

    // one register per cycle of delay
    payload_t stg [tcb_bus_pkg::dly];

    always_ff @(posedge clk) begin
        if (reset) begin
            // all stages start cleared
            for (int unsigned i = 0; i < tcb_bus_pkg::dly; i++) begin
                stg[i] <= '0;
            end
        end else begin
            // first stage samples the input
            stg[0] <= din;
            // remaining stages shift along
            for (int unsigned i = 1; i < tcb_bus_pkg::dly; i++) begin
                stg[i] <= stg[i-1];
            end
        end
    end

    ////////////////////
    // output
    ////////////////////

    // oldest stage
    assign dout = stg[tcb_bus_pkg::dly-1];

endmodule

// ==== verilog/tcb_logsize2byteena.sv ====
// TCB converter from logarithmic size requests to byte enables with lane rotation
module tcb_logsize2byteena (
    input  logic                             clk,
    input  logic                             reset,
    // manager side request
    input  logic                             req_vld,
    input  logic                             req_wen,
    input  logic                             req_ren,
    input  logic                             req_ndn,
    input  logic [tcb_bus_pkg::siz_w-1:0]    req_siz,
    input  logic [tcb_bus_pkg::adr_w-1:0]    req_adr,
    input  logic [tcb_bus_pkg::dat_w-1:0]    req_wdt,
    // manager side response
    output logic [tcb_bus_pkg::dat_w-1:0]    rsp_rdt,
    output logic                             rsp_err,
    // memory side request
    output logic                             mem_vld,
    output logic                             mem_wen,
    output logic                             mem_ren,
    output logic [tcb_bus_pkg::adr_w-1:0]    mem_adr,
    output logic [tcb_bus_pkg::byt_n-1:0]    mem_byt,
    output logic [tcb_bus_pkg::dat_w-1:0]    mem_wdt,
    // memory side response
    input  logic [tcb_bus_pkg::dat_w-1:0]    mem_rdt,
    input  logic                             mem_err
);

    ////////////////////
    // local signals
    ////////////////////

    // request offset and index of last byte
    logic [tcb_bus_pkg::off_w-1:0] req_off;
    logic [tcb_bus_pkg::off_w-1:0] req_lst;
    // response side last byte
    logic [tcb_bus_pkg::off_w-1:0] rsp_lst;

    // request record now and dly cycles later
    tcb_bus_pkg::rsp_meta_t req_meta;
    tcb_bus_pkg::rsp_meta_t rsp_meta;

    // data viewed as byte lanes
    logic [tcb_bus_pkg::byt_n-1:0][7:0] req_wdt_b;
    logic [tcb_bus_pkg::byt_n-1:0][7:0] mem_wdt_b;
    logic [tcb_bus_pkg::byt_n-1:0][7:0] mem_rdt_b;
    logic [tcb_bus_pkg::byt_n-1:0][7:0] rsp_rdt_b;

    // size to index of last byte (n-1)
    function automatic logic [tcb_bus_pkg::off_w-1:0] last_lane (
        input logic [tcb_bus_pkg::siz_w-1:0] siz
    );
        last_lane = tcb_bus_pkg::off_w'((1 << siz) - 1);
    endfunction

    ////////////////////
    // request
    ////////////////////

    // handshake and command pass straight through
    assign mem_vld = req_vld;
    assign mem_wen = req_wen;
    assign mem_ren = req_ren;
    assign mem_adr = req_adr;

    assign req_off = req_adr[tcb_bus_pkg::off_w-1:0];
    assign req_lst = last_lane(req_siz);

    // record for the response side
    assign req_meta = '{ndn: req_ndn, siz: req_siz, off: req_off};

    tcb_dly_line #(
        .payload_t (tcb_bus_pkg::rsp_meta_t)
    ) meta_dly (
        .clk   (clk),
        .reset (reset),
        .din   (req_meta),
        .dout  (rsp_meta)
    );

    assign rsp_lst = last_lane(rsp_meta.siz);

    ////////////////////
    // lane rotation
    ////////////////////

    assign req_wdt_b = req_wdt;
    assign mem_rdt_b = mem_rdt;

    // all lane arithmetic is off_w bits wide, so it wraps modulo 4
    for (genvar i = 0; i < tcb_bus_pkg::byt_n; i++) begin : gen_lane
        // this lane as an offset value
        logic [tcb_bus_pkg::off_w-1:0] lane;
        // write source bytes per endianness
        logic [tcb_bus_pkg::off_w-1:0] wr_le;
        logic [tcb_bus_pkg::off_w-1:0] wr_be;
        // read source lanes per endianness
        logic [tcb_bus_pkg::off_w-1:0] rd_le;
        logic [tcb_bus_pkg::off_w-1:0] rd_be;

        assign lane  = tcb_bus_pkg::off_w'(i);

        // little endian source byte, also the distance from the offset
        assign wr_le = lane - req_off;
        // big endian fills the addressed bytes in reverse
        assign wr_be = req_lst - lane + req_off;

        // enabled while within n bytes of the offset
        assign mem_byt[i] = (wr_le <= req_lst);

        // write data into addressed lanes
        assign mem_wdt_b[i] = req_ndn ? req_wdt_b[wr_be] : req_wdt_b[wr_le];

        // read data back to right-justified order
        assign rd_le = lane + rsp_meta.off;
        assign rd_be = rsp_lst - lane + rsp_meta.off;

        assign rsp_rdt_b[i] = rsp_meta.ndn ? mem_rdt_b[rd_be] : mem_rdt_b[rd_le];
    end

    assign mem_wdt = mem_wdt_b;

    ////////////////////
    // response
    ////////////////////

    assign rsp_rdt = rsp_rdt_b;
    // error comes from the memory unchanged
    assign rsp_err = mem_err;

    ////////////////////
    // checks
    ////////////////////

    // enabled byte count matches the requested size
    byt_cnt_chk: assert property (
        @(posedge clk) disable iff (reset)
        req_vld |-> ($countones(mem_byt) == (1 << req_siz))
    ) else $error("byte enable count %0d does not match size %0d",
                  $countones(mem_byt), req_siz);

endmodule

// ==== verilog/tcb_byte_mem.sv ====
// TCB byte-enabled word memory subordinate with one-cycle response and range error
module tcb_byte_mem (
    input  logic                             clk,
    input  logic                             reset,
    // request
    input  logic                             mem_vld,
    input  logic                             mem_wen,
    input  logic                             mem_ren,
    input  logic [tcb_bus_pkg::adr_w-1:0]    mem_adr,
    input  logic [tcb_bus_pkg::byt_n-1:0]    mem_byt,
    input  logic [tcb_bus_pkg::dat_w-1:0]    mem_wdt,
    // response
    output logic [tcb_bus_pkg::dat_w-1:0]    mem_rdt,
    output logic                             mem_err
);

    ////////////////////
    // storage
    ////////////////////

    // word array, byte lanes addressable
    logic [tcb_bus_pkg::byt_n-1:0][7:0] mem [tcb_mem_pkg::mem_words];

    // word index from the byte address
    logic [tcb_mem_pkg::mem_idx_w-1:0] idx;
    // address past the end of the array
    logic adr_err;
    // error of the accepted request
    logic req_err;

    logic [tcb_bus_pkg::byt_n-1:0][7:0] wdt_b;

    assign idx     = mem_adr[tcb_bus_pkg::off_w +: tcb_mem_pkg::mem_idx_w];
    assign adr_err = (mem_adr >= tcb_bus_pkg::adr_w'(tcb_mem_pkg::mem_adr_lim));
    assign wdt_b   = mem_wdt;

    ////////////////////
    // write
    ////////////////////

    // only enabled lanes, only in range
    always_ff @(posedge clk) begin
        if (mem_vld && mem_wen && !adr_err) begin
            for (int unsigned b = 0; b < tcb_bus_pkg::byt_n; b++) begin
                if (mem_byt[b]) begin
                    mem[idx][b] <= wdt_b[b];
                end
            end
        end
    end

    ////////////////////
    // read
    ////////////////////

    // whole word, registered
    always_ff @(posedge clk) begin
        if (mem_vld && mem_ren && !adr_err) begin
            mem_rdt <= mem[idx];
        end
    end

    ////////////////////
    // error
    ////////////////////

    assign req_err = mem_vld & adr_err;

    // aligned with the read data
    tcb_dly_line #(
        .payload_t (logic)
    ) err_dly (
        .clk   (clk),
        .reset (reset),
        .din   (req_err),
        .dout  (mem_err)
    );

    ////////////////////
    // checks
    ////////////////////

    // address fully known on every access
    adr_known_chk: assert property (
        @(posedge clk) disable iff (reset)
        mem_vld |-> !$isunknown(mem_adr)
    ) else $error("unknown address bits on a valid access");

    // no combined read and write
    wen_ren_chk: assert property (
        @(posedge clk) disable iff (reset)
        !(mem_wen && mem_ren)
    ) else $error("write and read enable both high");

endmodule

// ==== verilog/tcb_sys_top.sv ====
// TCB subsystem top joining the byte-enable converter and the word memory
module tcb_sys_top (
    input  logic                             clk,
    input  logic                             reset,
    // manager request
    input  logic                             req_vld,
    input  logic                             req_wen,
    input  logic                             req_ren,
    input  logic                             req_ndn,
    input  logic [tcb_bus_pkg::siz_w-1:0]    req_siz,
    input  logic [tcb_bus_pkg::adr_w-1:0]    req_adr,
    input  logic [tcb_bus_pkg::dat_w-1:0]    req_wdt,
    // manager response, one cycle after the request
    output logic [tcb_bus_pkg::dat_w-1:0]    rsp_rdt,
    output logic                             rsp_err
);

    ////////////////////
    // internal bus
    ////////////////////

    // converter to memory request
    logic                          mem_vld;
    logic                          mem_wen;
    logic                          mem_ren;
    logic [tcb_bus_pkg::adr_w-1:0] mem_adr;
    logic [tcb_bus_pkg::byt_n-1:0] mem_byt;
    logic [tcb_bus_pkg::dat_w-1:0] mem_wdt;
    // memory to converter response
    logic [tcb_bus_pkg::dat_w-1:0] mem_rdt;
    logic                          mem_err;

    ////////////////////
    // converter
    ////////////////////

    tcb_logsize2byteena cnv (
        .clk     (clk),
        .reset   (reset),
        .req_vld (req_vld),
        .req_wen (req_wen),
        .req_ren (req_ren),
        .req_ndn (req_ndn),
        .req_siz (req_siz),
        .req_adr (req_adr),
        .req_wdt (req_wdt),
        .rsp_rdt (rsp_rdt),
        .rsp_err (rsp_err),
        .mem_vld (mem_vld),
        .mem_wen (mem_wen),
        .mem_ren (mem_ren),
        .mem_adr (mem_adr),
        .mem_byt (mem_byt),
        .mem_wdt (mem_wdt),
        .mem_rdt (mem_rdt),
        .mem_err (mem_err)
    );

    ////////////////////
    // memory
    ////////////////////

    tcb_byte_mem mem (
        .clk     (clk),
        .reset   (reset),
        .mem_vld (mem_vld),
        .mem_wen (mem_wen),
        .mem_ren (mem_ren),
        .mem_adr (mem_adr),
        .mem_byt (mem_byt),
        .mem_wdt (mem_wdt),
        .mem_rdt (mem_rdt),
        .mem_err (mem_err)
    );

endmodule

// ==== dv/tcb_sys_tb.sv ====
// TCB subsystem testbench with LCG stimulus, byte-level reference model and assertion checks
module tcb_sys_tb;

    ////////////////////
    // test lengths
    ////////////////////

    // words in the random window
    localparam int unsigned win_words = 16;
    // random requests
    localparam int unsigned rnd_n     = 400;
    // requests over all tests
    localparam int unsigned txn_n = 12 * 2 + 12 * 3 + 10 + 4 + win_words + rnd_n;

    logic                          clk;
    logic                          reset;
    logic                          req_vld;
    logic                          req_wen;
    logic                          req_ren;
    logic                          req_ndn;
    logic [tcb_bus_pkg::siz_w-1:0] req_siz;
    logic [tcb_bus_pkg::adr_w-1:0] req_adr;
    logic [tcb_bus_pkg::dat_w-1:0] req_wdt;
    logic [tcb_bus_pkg::dat_w-1:0] rsp_rdt;
    logic                          rsp_err;

    // byte image of the memory
    logic [7:0] ref_mem [tcb_mem_pkg::mem_adr_lim];

    // expectation of the request now on the bus
    logic [tcb_bus_pkg::dat_w-1:0] nxt_rdt;
    logic [tcb_bus_pkg::dat_w-1:0] nxt_msk;
    logic                          nxt_chk;
    logic                          nxt_err;
    string                         cur_name;

    // expectation of the response now on the bus
    logic [tcb_bus_pkg::dat_w-1:0] exp_rdt;
    logic [tcb_bus_pkg::dat_w-1:0] exp_msk;
    logic                          exp_chk;
    logic                          exp_err;
    string                         exp_name;
    // error flag known once reset has been clocked
    logic                          err_chk_en;

    logic [31:0] rng;

    tcb_sys_top dut (
        .clk     (clk),
        .reset   (reset),
        .req_vld (req_vld),
        .req_wen (req_wen),
        .req_ren (req_ren),
        .req_ndn (req_ndn),
        .req_siz (req_siz),
        .req_adr (req_adr),
        .req_wdt (req_wdt),
        .rsp_rdt (rsp_rdt),
        .rsp_err (rsp_err)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // expectation follows the request by one cycle
    always @(posedge clk) begin
        exp_name <= cur_name;
        if (reset) begin
            exp_chk    <= 1'b0;
            exp_err    <= 1'b0;
            err_chk_en <= 1'b1;
        end else begin
            exp_rdt <= nxt_rdt;
            exp_msk <= nxt_msk;
            exp_chk <= nxt_chk;
            exp_err <= nxt_err;
        end
    end

    ////////////////////
    // checks
    ////////////////////

    task automatic fail_mismatch(input string name, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
        $display("ERROR %s: %s expected %h actual %h", name, what, exp, act);
        $display("SIMULATION FAILED");
        $fatal(1, "response mismatch");
    endtask

    // responses compared on the falling edge
    rdt_chk: assert property (@(negedge clk) exp_chk |-> ((rsp_rdt & exp_msk) == exp_rdt))
        else fail_mismatch(exp_name, "rsp_rdt", exp_rdt, rsp_rdt & exp_msk);

    err_chk: assert property (@(negedge clk) err_chk_en |-> (rsp_err == exp_err))
        else fail_mismatch(exp_name, "rsp_err", 32'(exp_err), 32'(rsp_err));

    initial begin
        #((txn_n + 100) * 4);
        $display("watchdog expired before the tests finished");
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    end

    ////////////////////
    // stimulus
    ////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // drives one request on the falling edge and updates the model
    task automatic issue(input string name, input logic wen, input logic ndn,
                         input logic [tcb_bus_pkg::siz_w-1:0] siz,
                         input logic [tcb_bus_pkg::adr_w-1:0] adr,
                         input logic [tcb_bus_pkg::dat_w-1:0] wdt);
        int n;
        int off;
        int base;
        int lane;
        int src;
        @(negedge clk);
        req_vld  = 1'b1;
        req_wen  = wen;
        req_ren  = !wen;
        req_ndn  = ndn;
        req_siz  = siz;
        req_adr  = adr;
        req_wdt  = wdt;
        cur_name = name;
        n    = 1 << siz;
        off  = int'(adr[1:0]);
        base = int'(adr[tcb_bus_pkg::adr_w-1:2]) * 4;
        nxt_err = (adr >= tcb_mem_pkg::mem_adr_lim);
        nxt_chk = !wen && !nxt_err;
        nxt_rdt = '0;
        nxt_msk = '0;
        // k-th addressed byte sits in lane off+k modulo 4
        for (int k = 0; k < n; k++) begin
            lane = (off + k) % 4;
            if (wen && !nxt_err) begin
                // big endian puts the top source byte first
                src = ndn ? (n - 1 - k) : k;
                ref_mem[base + lane] = wdt[8*src +: 8];
            end
            if (nxt_chk) begin
                lane = ndn ? ((n - 1 - k + off) % 4) : lane;
                nxt_rdt[8*k +: 8] = ref_mem[base + lane];
                nxt_msk[8*k +: 8] = 8'hff;
            end
        end
    endtask

    task automatic write_req(input string name, input logic ndn,
                             input logic [tcb_bus_pkg::siz_w-1:0] siz,
                             input logic [tcb_bus_pkg::adr_w-1:0] adr,
                             input logic [tcb_bus_pkg::dat_w-1:0] wdt);
        issue(name, 1'b1, ndn, siz, adr, wdt);
    endtask

    task automatic read_req(input string name, input logic ndn,
                            input logic [tcb_bus_pkg::siz_w-1:0] siz,
                            input logic [tcb_bus_pkg::adr_w-1:0] adr);
        issue(name, 1'b0, ndn, siz, adr, '0);
    endtask

    task automatic go_idle();
        @(negedge clk);
        req_vld = 1'b0;
        req_wen = 1'b0;
        req_ren = 1'b0;
        nxt_chk = 1'b0;
        nxt_err = 1'b0;
    endtask

    initial begin
        logic [31:0]                   r;
        logic [tcb_bus_pkg::adr_w-1:0] adr;
        logic [tcb_bus_pkg::siz_w-1:0] siz;
        rng        = 32'hc3ce4731;
        reset      = 1'b1;
        req_vld    = 1'b0;
        req_wen    = 1'b0;
        req_ren    = 1'b0;
        req_ndn    = 1'b0;
        req_siz    = '0;
        req_adr    = '0;
        req_wdt    = '0;
        nxt_rdt    = '0;
        nxt_msk    = '0;
        nxt_chk    = 1'b0;
        nxt_err    = 1'b0;
        err_chk_en = 1'b0;
        cur_name   = "reset";
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // little endian round trip over every size and offset
        for (int s = 0; s < 3; s++) begin
            for (int o = 0; o < 4; o++) begin
                adr = 12'h100 + 12'((s * 4 + o) * 4 + o);
                rng = lcg_next(rng);
                write_req("le_rw", 1'b0, 2'(s), adr, rng);
                read_req("le_rw", 1'b0, 2'(s), adr);
            end
        end

        // big endian write seen through a little endian word read
        for (int s = 0; s < 3; s++) begin
            for (int o = 0; o < 4; o++) begin
                adr = 12'h200 + 12'((s * 4 + o) * 4 + o);
                rng = lcg_next(rng);
                write_req("be_place", 1'b0, 2'd2, {adr[11:2], 2'b00}, rng);
                rng = lcg_next(rng);
                write_req("be_place", 1'b1, 2'(s), adr, rng);
                read_req("be_place", 1'b0, 2'd2, {adr[11:2], 2'b00});
            end
        end

        // word write at offset 3 wraps round before single byte reads
        for (int e = 0; e < 2; e++) begin
            adr = 12'h300 + 12'(4 * e);
            rng = lcg_next(rng);
            write_req("wrap", e[0], 2'd2, adr + 12'd3, rng);
            for (int o = 0; o < 4; o++) begin
                read_req("wrap", e[0], 2'd0, adr + 12'(o));
            end
        end

        // 0x8a8 aliases 0x0a8 in the array but must not touch it
        rng = lcg_next(rng);
        write_req("range", 1'b0, 2'd2, 12'h0a8, rng);
        rng = lcg_next(rng);
        write_req("range", 1'b0, 2'd2, 12'h8a8, rng);
        read_req("range", 1'b0, 2'd2, 12'h0a8);
        read_req("range", 1'b0, 2'd2, 12'h8a8);

        // fill the window so every random read is defined
        for (int w = 0; w < win_words; w++) begin
            rng = lcg_next(rng);
            write_req("random", 1'b0, 2'd2, 12'h400 + 12'(4 * w), rng);
        end
        for (int t = 0; t < rnd_n; t++) begin
            rng = lcg_next(rng);
            r   = rng;
            siz = (r[29:28] == 2'd3) ? 2'd2 : r[29:28];
            adr = 12'h400 + {6'd0, r[21:16]};
            // about one in eight lands past the memory
            if (r[27:25] == 3'd0) begin
                adr = adr | 12'h800;
            end
            rng = lcg_next(rng);
            issue("random", r[31], r[30], siz, adr, rng);
        end

        // let the last response pass the checks
        go_idle();
        @(negedge clk);
        @(negedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== all.f ====
verilog/tcb_bus_pkg.sv
verilog/tcb_mem_pkg.sv
verilog/tcb_dly_line.sv
verilog/tcb_logsize2byteena.sv
verilog/tcb_byte_mem.sv
verilog/tcb_sys_top.sv
dv/tcb_sys_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the TCB subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tcb_sys_tb -f all.f -o tcb_sys_sim || exit 1

out="$(./obj_dir/tcb_sys_sim 2>&1)"
echo "$out"

# pass only when the testbench reports it
echo "$out" | grep -qx "SIMULATION PASSED" && exit 0 || exit 1
